// ==== rtl/cache_pkg.sv ====
package cache_pkg;

   // address split: tag | index | offset
   localparam int word_w   = 16;  // data word
   localparam int addr_w   = 16;  // word address
   localparam int offset_w = 2;   // word within line
   localparam int index_w  = 4;   // line select
   localparam int tag_w    = addr_w - index_w - offset_w;

   localparam int words_per_line = 4;
   localparam int num_lines      = 16;

   // main memory timing
   localparam int bank_busy_cycles = 3;  // bank blocked after an access
   localparam int rd_latency       = 2;  // accept to rd_valid

   // controller states, 1 and 2 left free
   typedef enum logic [3:0] {
      idle      = 4'h0,
      wb_0      = 4'h3,  // write back victim words
      wb_1      = 4'h4,
      wb_2      = 4'h5,
      wb_3      = 4'h6,
      alloc_0   = 4'h7,  // issue line reads
      alloc_1   = 4'h8,
      alloc_2   = 4'h9,
      alloc_3   = 4'ha,
      fill_wait = 4'hb,  // wait for remaining returns
      commit    = 4'hc,  // mark line valid
      rd_retry  = 4'hd,
      wr_retry  = 4'he,
      error     = 4'hf   // rd and wr together
   } ctrl_state_t;

   // reset contents of main memory
   function automatic logic [word_w-1:0] mem_init_word(input logic [addr_w-1:0] a);
      return ~a;
   endfunction

endpackage

// ==== rtl/cache_array.sv ====
`timescale 1ns/1ps

module cache_array (
   input  logic clk,
   input  logic rst_n,
   input  logic [cache_pkg::addr_w-1:0] addr,   // client address, held
   input  logic [cache_pkg::word_w-1:0] wdata,
   input  logic c_comp,
   input  logic c_write,
   input  logic c_valid_in,
   input  logic [cache_pkg::offset_w-1:0] c_offset,
   input  logic fill_valid,                     // memory return
   input  logic [cache_pkg::offset_w-1:0] fill_offset,
   input  logic [cache_pkg::word_w-1:0] fill_data,
   output logic hit,
   output logic dirty,
   output logic valid,
   output logic [cache_pkg::tag_w-1:0] victim_tag,
   output logic [cache_pkg::word_w-1:0] rdata
);
   import cache_pkg::*;

   logic [tag_w-1:0]    req_tag;
   logic [index_w-1:0]  idx;
   logic [offset_w-1:0] req_off;
   logic [offset_w-1:0] rd_off;
   logic                wr_hit;

   logic [tag_w-1:0]  tag_mem  [num_lines];
   logic [word_w-1:0] data_mem [num_lines][words_per_line];
   logic [num_lines-1:0] valid_q;
   logic [num_lines-1:0] dirty_q;

   assign req_tag = addr[addr_w-1 -: tag_w];
   assign idx     = addr[offset_w +: index_w];
   assign req_off = addr[offset_w-1:0];

   // tag compare only in compare mode
   assign hit        = c_comp & (tag_mem[idx] == req_tag);
   assign valid      = valid_q[idx];
   assign dirty      = dirty_q[idx];
   assign victim_tag = tag_mem[idx];

   assign rd_off = c_comp ? req_off : c_offset;  // client word or wb word
   assign rdata  = data_mem[idx][rd_off];

   assign wr_hit = c_comp & c_write & hit & valid;

   always_ff @(posedge clk) begin
      if (wr_hit) begin
         data_mem[idx][req_off] <= wdata;
      end
      if (fill_valid) begin
         data_mem[idx][fill_offset] <= fill_data;  // one word per return
      end
      if (c_valid_in) begin
         tag_mem[idx] <= req_tag;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (c_valid_in) begin
         valid_q[idx] <= 1'b1;  // freshly filled line is clean
         dirty_q[idx] <= 1'b0;
      end else if (wr_hit) begin
         dirty_q[idx] <= 1'b1;
      end
   end

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
   input  logic clk,
   input  logic rst_n,
   // client side
   input  logic rd,            // held until done
   input  logic wr,
   // from cache array
   input  logic hit,
   input  logic dirty,
   input  logic valid,
   // from arbiter
   input  logic m_stall,
   input  logic rd_valid,      // fill word arriving
   output logic done,
   output logic err,
   output logic stall,
   // to cache array
   output logic c_comp,
   output logic c_write,
   output logic c_valid_in,
   output logic [cache_pkg::offset_w-1:0] c_offset,
   // to arbiter
   output logic m_rd,
   output logic m_wr,
   output logic m_lock,
   output logic [cache_pkg::offset_w-1:0] m_offset,
   output logic m_sel_victim,  // victim tag on writeback
   output cache_pkg::ctrl_state_t state
);
   import cache_pkg::*;

   ctrl_state_t nxt;
   logic in_wb;
   logic in_alloc;
   logic [offset_w:0] fill_cnt;  // fill words seen this burst
   logic fill_last;

   assign in_wb    = state inside {wb_0, wb_1, wb_2, wb_3};
   assign in_alloc = state inside {alloc_0, alloc_1, alloc_2, alloc_3};

   // fourth return arrives this cycle
   assign fill_last = rd_valid & (fill_cnt == (offset_w+1)'(words_per_line - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         state <= nxt;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fill_cnt <= '0;
      end else if (state == idle) begin
         fill_cnt <= '0;                 // fresh count per miss
      end else if (rd_valid) begin
         fill_cnt <= fill_cnt + 1'b1;    // returns may land during alloc
      end
   end

   // hit | valid | dirty decides in idle, same table as before
   always_comb begin
      nxt = state;
      case (state)
         idle: begin
            if (rd & wr) begin
               nxt = error;
            end else if ((rd | wr) & ~(hit & valid)) begin
               nxt = (dirty & valid) ? wb_0 : alloc_0;  // dirty victim goes out first
            end
         end
         wb_0:      nxt = m_stall ? wb_0 : wb_1;
         wb_1:      nxt = m_stall ? wb_1 : wb_2;
         wb_2:      nxt = m_stall ? wb_2 : wb_3;
         wb_3:      nxt = m_stall ? wb_3 : alloc_0;
         alloc_0:   nxt = m_stall ? alloc_0 : alloc_1;
         alloc_1:   nxt = m_stall ? alloc_1 : alloc_2;
         alloc_2:   nxt = m_stall ? alloc_2 : alloc_3;
         alloc_3:   nxt = m_stall ? alloc_3 : fill_wait;
         fill_wait: nxt = fill_last ? commit : fill_wait;
         commit: begin
            if (rd) begin
               nxt = rd_retry;
            end else if (wr) begin
               nxt = wr_retry;
            end else begin
               nxt = error;   // client let go mid miss
            end
         end
         rd_retry:  nxt = idle;
         wr_retry:  nxt = idle;
         error:     nxt = idle;
         default:   nxt = idle;
      endcase
   end

   // word offset walked by wb and alloc
   always_comb begin
      case (state)
         wb_1, alloc_1: m_offset = 2'd1;
         wb_2, alloc_2: m_offset = 2'd2;
         wb_3, alloc_3: m_offset = 2'd3;
         default:       m_offset = 2'd0;
      endcase
   end

   assign c_offset = m_offset;  // array reads victim word in step

   assign stall = (state != idle);
   assign err   = (state == error);

   // compare on a clean request in idle and on both retries
   assign c_comp = ((state == idle) & (rd ^ wr))
                 | (state == rd_retry)
                 | (state == wr_retry);
   assign c_write    = c_comp & wr;
   assign c_valid_in = (state == commit);

   // retry always hits, idle only on a valid tag match
   assign done = c_comp & ((state != idle) | (hit & valid));

   assign m_wr         = in_wb;
   assign m_rd         = in_alloc;
   assign m_sel_victim = in_wb;
   assign m_lock       = in_wb | in_alloc | (state == fill_wait) | (state == commit);

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
   input  logic clk,
   input  logic rst_n,
   input  logic m_rd_0,
   input  logic m_wr_0,
   input  logic m_lock_0,
   input  logic [cache_pkg::addr_w-1:0] m_addr_0,
   input  logic [cache_pkg::word_w-1:0] m_wdata_0,
   input  logic m_rd_1,
   input  logic m_wr_1,
   input  logic m_lock_1,
   input  logic [cache_pkg::addr_w-1:0] m_addr_1,
   input  logic [cache_pkg::word_w-1:0] m_wdata_1,
   input  logic mem_stall,
   input  logic mem_rd_valid,
   input  logic [cache_pkg::word_w-1:0] mem_rd_data,
   input  logic [cache_pkg::offset_w-1:0] mem_rd_offset,
   output logic m_stall_0,
   output logic m_stall_1,
   output logic rd_valid_0,
   output logic rd_valid_1,
   output logic [cache_pkg::word_w-1:0] rd_data,
   output logic [cache_pkg::offset_w-1:0] rd_offset,
   output logic mem_rd,
   output logic mem_wr,
   output logic [cache_pkg::addr_w-1:0] mem_addr,
   output logic [cache_pkg::word_w-1:0] mem_wdata
);

   logic owner;    // last granted port, doubles as rr pointer
   logic burst_q;  // owner held lock last cycle
   logic gnt;
   logic owner_lock;

   assign owner_lock = owner ? m_lock_1 : m_lock_0;

   always_comb begin
      if (burst_q & owner_lock) begin
         gnt = owner;                 // burst in progress, no switch
      end else if (m_lock_0 & m_lock_1) begin
         gnt = ~owner;                // tie, last owner loses
      end else if (m_lock_0 | m_lock_1) begin
         gnt = m_lock_1;
      end else begin
         gnt = owner;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner   <= 1'b0;
         burst_q <= 1'b0;
      end else begin
         owner   <= gnt;
         burst_q <= gnt ? m_lock_1 : m_lock_0;
      end
   end

   // granted stream straight to memory
   assign mem_rd    = gnt ? m_rd_1    : m_rd_0;
   assign mem_wr    = gnt ? m_wr_1    : m_wr_0;
   assign mem_addr  = gnt ? m_addr_1  : m_addr_0;
   assign mem_wdata = gnt ? m_wdata_1 : m_wdata_0;

   assign m_stall_0 = gnt | mem_stall;   // loser waits
   assign m_stall_1 = ~gnt | mem_stall;

   // owner still locked while its reads return
   assign rd_valid_0 = mem_rd_valid & ~owner;
   assign rd_valid_1 = mem_rd_valid & owner;
   assign rd_data    = mem_rd_data;
   assign rd_offset  = mem_rd_offset;

endmodule

// ==== rtl/main_mem.sv ====
`timescale 1ns/1ps

module main_mem (
   input  logic clk,
   input  logic rst_n,
   input  logic mem_rd,
   input  logic mem_wr,
   input  logic [cache_pkg::addr_w-1:0] mem_addr,
   input  logic [cache_pkg::word_w-1:0] mem_wdata,
   output logic mem_stall,        // addressed bank busy
   output logic mem_rd_valid,
   output logic [cache_pkg::word_w-1:0] mem_rd_data,
   output logic [cache_pkg::offset_w-1:0] mem_rd_offset
);
   import cache_pkg::*;

   typedef logic [$clog2(bank_busy_cycles + 1)-1:0] busy_t;

   logic [word_w-1:0] bank_mem [words_per_line][2**(addr_w-offset_w)];  // bank per offset
   busy_t busy_cnt [words_per_line];
   logic [offset_w-1:0] bank;
   logic [addr_w-offset_w-1:0] row;
   logic accept;

   // read return pipe, slot 0 loaded at accept
   logic [rd_latency-1:0] pipe_v;
   logic [word_w-1:0]   pipe_data [rd_latency];
   logic [offset_w-1:0] pipe_off  [rd_latency];

   assign bank   = mem_addr[offset_w-1:0];
   assign row    = mem_addr[addr_w-1:offset_w];
   assign mem_stall = (mem_rd | mem_wr) & (busy_cnt[bank] != '0);
   assign accept    = (mem_rd | mem_wr) & ~mem_stall;

   initial begin
      for (int b = 0; b < words_per_line; b++) begin
         for (int r = 0; r < 2**(addr_w-offset_w); r++) begin
            bank_mem[b][r] = mem_init_word(addr_w'(r * words_per_line + b));
         end
      end
   end

   always @(posedge clk) begin
      if (accept & mem_wr) begin
         bank_mem[bank][row] <= mem_wdata;  // lands on accepting edge
      end
   end

   // busy countdown per bank
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < words_per_line; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < words_per_line; b++) begin
            if (accept && (bank == offset_w'(b))) begin
               busy_cnt[b] <= busy_t'(bank_busy_cycles);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pipe_v <= '0;
      end else begin
         pipe_v <= {pipe_v[rd_latency-2:0], accept & mem_rd};
      end
   end

   always_ff @(posedge clk) begin
      pipe_data[0] <= bank_mem[bank][row];
      pipe_off[0]  <= bank;   // offset tag for the fill
      for (int s = 1; s < rd_latency; s++) begin
         pipe_data[s] <= pipe_data[s-1];
         pipe_off[s]  <= pipe_off[s-1];
      end
   end

   assign mem_rd_valid  = pipe_v[rd_latency-1];
   assign mem_rd_data   = pipe_data[rd_latency-1];
   assign mem_rd_offset = pipe_off[rd_latency-1];

endmodule

// ==== rtl/cache_sys_top.sv ====
`timescale 1ns/1ps

module cache_sys_top (
   input  logic clk,
   input  logic rst_n,
   input  logic rd_0,
   input  logic wr_0,
   input  logic [cache_pkg::addr_w-1:0] addr_0,
   input  logic [cache_pkg::word_w-1:0] wdata_0,
   input  logic rd_1,
   input  logic wr_1,
   input  logic [cache_pkg::addr_w-1:0] addr_1,
   input  logic [cache_pkg::word_w-1:0] wdata_1,
   output logic done_0,
   output logic [cache_pkg::word_w-1:0] rdata_0,
   output logic stall_0,
   output logic err_0,
   output logic done_1,
   output logic [cache_pkg::word_w-1:0] rdata_1,
   output logic stall_1,
   output logic err_1
);
   import cache_pkg::*;

   // controller <-> array, per port
   logic hit_0, hit_1;
   logic dirty_0, dirty_1;
   logic valid_0, valid_1;
   logic [tag_w-1:0] victim_tag_0, victim_tag_1;
   logic c_comp_0, c_comp_1;
   logic c_write_0, c_write_1;
   logic c_valid_in_0, c_valid_in_1;
   logic [offset_w-1:0] c_offset_0, c_offset_1;

   // controller <-> arbiter
   logic m_rd_0, m_rd_1;
   logic m_wr_0, m_wr_1;
   logic m_lock_0, m_lock_1;
   logic m_sel_victim_0, m_sel_victim_1;
   logic [offset_w-1:0] m_offset_0, m_offset_1;
   logic [addr_w-1:0] m_addr_0, m_addr_1;
   logic m_stall_0, m_stall_1;
   logic rd_valid_0, rd_valid_1;
   logic [word_w-1:0] rd_data;       // shared return path
   logic [offset_w-1:0] rd_offset;

   // arbiter <-> memory
   logic mem_rd, mem_wr, mem_stall, mem_rd_valid;
   logic [addr_w-1:0] mem_addr;
   logic [word_w-1:0] mem_wdata, mem_rd_data;
   logic [offset_w-1:0] mem_rd_offset;

   // line address, victim tag during writeback
   assign m_addr_0 = {m_sel_victim_0 ? victim_tag_0 : addr_0[addr_w-1 -: tag_w],
                      addr_0[offset_w +: index_w], m_offset_0};
   assign m_addr_1 = {m_sel_victim_1 ? victim_tag_1 : addr_1[addr_w-1 -: tag_w],
                      addr_1[offset_w +: index_w], m_offset_1};

   cache_ctrl ctrl_0 (
      .clk, .rst_n, .rd(rd_0), .wr(wr_0),
      .hit(hit_0), .dirty(dirty_0), .valid(valid_0),
      .m_stall(m_stall_0), .rd_valid(rd_valid_0),
      .done(done_0), .err(err_0), .stall(stall_0),
      .c_comp(c_comp_0), .c_write(c_write_0), .c_valid_in(c_valid_in_0),
      .c_offset(c_offset_0),
      .m_rd(m_rd_0), .m_wr(m_wr_0), .m_lock(m_lock_0),
      .m_offset(m_offset_0), .m_sel_victim(m_sel_victim_0), .state()
   );

   cache_ctrl ctrl_1 (
      .clk, .rst_n, .rd(rd_1), .wr(wr_1),
      .hit(hit_1), .dirty(dirty_1), .valid(valid_1),
      .m_stall(m_stall_1), .rd_valid(rd_valid_1),
      .done(done_1), .err(err_1), .stall(stall_1),
      .c_comp(c_comp_1), .c_write(c_write_1), .c_valid_in(c_valid_in_1),
      .c_offset(c_offset_1),
      .m_rd(m_rd_1), .m_wr(m_wr_1), .m_lock(m_lock_1),
      .m_offset(m_offset_1), .m_sel_victim(m_sel_victim_1), .state()
   );

   cache_array array_0 (
      .clk, .rst_n, .addr(addr_0), .wdata(wdata_0),
      .c_comp(c_comp_0), .c_write(c_write_0), .c_valid_in(c_valid_in_0),
      .c_offset(c_offset_0),
      .fill_valid(rd_valid_0), .fill_offset(rd_offset), .fill_data(rd_data),
      .hit(hit_0), .dirty(dirty_0), .valid(valid_0),
      .victim_tag(victim_tag_0), .rdata(rdata_0)
   );

   cache_array array_1 (
      .clk, .rst_n, .addr(addr_1), .wdata(wdata_1),
      .c_comp(c_comp_1), .c_write(c_write_1), .c_valid_in(c_valid_in_1),
      .c_offset(c_offset_1),
      .fill_valid(rd_valid_1), .fill_offset(rd_offset), .fill_data(rd_data),
      .hit(hit_1), .dirty(dirty_1), .valid(valid_1),
      .victim_tag(victim_tag_1), .rdata(rdata_1)
   );

   // writeback data is the array word at c_offset
   mem_arbiter arb (
      .clk, .rst_n,
      .m_rd_0, .m_wr_0, .m_lock_0, .m_addr_0, .m_wdata_0(rdata_0),
      .m_rd_1, .m_wr_1, .m_lock_1, .m_addr_1, .m_wdata_1(rdata_1),
      .mem_stall, .mem_rd_valid, .mem_rd_data, .mem_rd_offset,
      .m_stall_0, .m_stall_1, .rd_valid_0, .rd_valid_1,
      .rd_data, .rd_offset,
      .mem_rd, .mem_wr, .mem_addr, .mem_wdata
   );

   main_mem mem (
      .clk, .rst_n, .mem_rd, .mem_wr, .mem_addr, .mem_wdata,
      .mem_stall, .mem_rd_valid, .mem_rd_data, .mem_rd_offset
   );

endmodule

// ==== test/cache_sys_chk.sv ====
`timescale 1ns/1ps

module cache_sys_chk (
   input logic clk,
   input logic rst_n,
   input logic rd,
   input logic wr,
   input logic done,
   input logic m_rd,
   input logic m_wr,
   input cache_pkg::ctrl_state_t state
);
   import cache_pkg::*;

   logic done_state;  // states allowed to finish a request

   assign done_state = (state == idle) || (state == rd_retry) || (state == wr_retry);

   // one memory command at a time
   a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n) !(m_rd && m_wr))
      else $error("controller drives m_rd and m_wr together");

   // done only from idle hit or a retry, and only for a single held request
   a_done_state: assert property (@(posedge clk) disable iff (!rst_n)
                                  done |-> done_state && (rd ^ wr))
      else $error("done high in state %0d without a single held request", state);

   a_error_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                  (state == error) |=> (state == idle))
      else $error("error state not followed by idle");

endmodule

bind cache_ctrl cache_sys_chk chk (
   .clk(clk), .rst_n(rst_n), .rd(rd), .wr(wr), .done(done), .m_rd(m_rd), .m_wr(m_wr),
   .state(state)
);

// ==== test/cache_sys_tb.sv ====
`timescale 1ns/1ps

module cache_sys_tb;
   import cache_pkg::*;

   localparam int n_cold    = 10;  // 4 on port 1, then 6 on port 0
   localparam int n_hit     = 4;
   localparam int n_raw     = 60;
   localparam int n_evict   = 9;   // 3 rounds of write, evict, reread
   localparam int n_contend = 40;  // per port
   localparam int n_err     = 2;
   localparam int total_ops = n_cold + n_hit + n_raw + n_evict + 2 * n_contend + n_err;
   localparam int timeout_cycles = total_ops * 40;
   localparam int access_limit   = 40;  // worst dirty miss under contention fits easily

   logic clk;
   logic rst_n;
   logic rd_0, wr_0, rd_1, wr_1;
   logic [addr_w-1:0] addr_0, addr_1;
   logic [word_w-1:0] wdata_0, wdata_1;
   logic done_0, stall_0, err_0, done_1, stall_1, err_1;
   logic [word_w-1:0] rdata_0, rdata_1;

   logic [word_w-1:0] ref_mem [logic [addr_w-1:0]];  // only written words stored
   logic [tag_w-1:0] shadow_tag [2][num_lines];      // what each cache should hold
   bit shadow_valid [2][num_lines];
   string cur_test;
   int n_checks, n_errors, base_checks, base_errors;
   int cycle_cnt;

   cache_sys_top uut (
      .clk(clk), .rst_n(rst_n),
      .rd_0(rd_0), .wr_0(wr_0), .addr_0(addr_0), .wdata_0(wdata_0),
      .rd_1(rd_1), .wr_1(wr_1), .addr_1(addr_1), .wdata_1(wdata_1),
      .done_0(done_0), .rdata_0(rdata_0), .stall_0(stall_0), .err_0(err_0),
      .done_1(done_1), .rdata_1(rdata_1), .stall_1(stall_1), .err_1(err_1)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   // hard stop in case a port never finishes
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < timeout_cycles) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Checks failed");
      $finish;
   end

   function automatic logic done_of(input int port);
      return (port == 0) ? done_0 : done_1;
   endfunction

   function automatic logic err_of(input int port);
      return (port == 0) ? err_0 : err_1;
   endfunction

   function automatic logic stall_of(input int port);
      return (port == 0) ? stall_0 : stall_1;
   endfunction

   // untouched memory holds the inverted address
   function automatic logic [word_w-1:0] model_read(input logic [addr_w-1:0] a);
      if (ref_mem.exists(a)) begin
         return ref_mem[a];
      end
      return ~a;
   endfunction

   function automatic bit predict_hit(input int port, input logic [addr_w-1:0] a);
      logic [index_w-1:0] idx;
      idx = a[offset_w +: index_w];
      return shadow_valid[port][idx] && (shadow_tag[port][idx] == a[addr_w-1 -: tag_w]);
   endfunction

   // tags 4*port .. 4*port+3 on indexes 0..2, so lines collide per port only
   function automatic logic [addr_w-1:0] pick_addr(input int port);
      logic [tag_w-1:0] tag;
      logic [index_w-1:0] idx;
      logic [offset_w-1:0] off;
      tag = tag_w'(port * 4) + tag_w'($urandom_range(3, 0));
      idx = index_w'($urandom_range(2, 0));
      off = offset_w'($urandom_range(3, 0));
      return {tag, idx, off};
   endfunction

   task automatic check_word(input string what, input logic [word_w-1:0] exp,
                             input logic [word_w-1:0] got);
      n_checks++;
      assert (got === exp) else begin
         $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_count(input string what, input int exp, input int got);
      n_checks++;
      assert (got == exp) else begin
         $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string msg);
      n_checks++;
      assert (cond) else begin
         $display("error in %s: %s", cur_test, msg);
         n_errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      base_checks = n_checks;
      base_errors = n_errors;
   endtask

   task automatic finish_test();
      $display("test %s: %0d checks, %0d errors", cur_test,
               n_checks - base_checks, n_errors - base_errors);
   endtask

   task automatic drive(input int port, input logic req_rd, input logic req_wr,
                        input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
      if (port == 0) begin
         rd_0    = req_rd;
         wr_0    = req_wr;
         addr_0  = a;
         wdata_0 = d;
      end else begin
         rd_1    = req_rd;
         wr_1    = req_wr;
         addr_1  = a;
         wdata_1 = d;
      end
   endtask

   // request held until done, outputs sampled on the falling edge
   task automatic access(input int port, input bit is_wr, input logic [addr_w-1:0] a,
                         input logic [word_w-1:0] d, output logic [word_w-1:0] rdata,
                         output int waited);
      bit seen;
      bit hit_exp;
      bit saw_stall;
      logic [index_w-1:0] idx;
      idx       = a[offset_w +: index_w];
      hit_exp   = predict_hit(port, a);
      rdata     = '0;
      waited    = 0;
      seen      = 1'b0;
      saw_stall = 1'b0;
      @(posedge clk);
      #2;
      drive(port, !is_wr, is_wr, a, d);
      while (!seen && waited < access_limit) begin
         @(negedge clk);
         if (done_of(port)) begin
            seen  = 1'b1;
            rdata = (port == 0) ? rdata_0 : rdata_1;
            if (is_wr) begin
               ref_mem[a] = d;  // model follows done order
            end
            shadow_valid[port][idx] = 1'b1;
            shadow_tag[port][idx]   = a[addr_w-1 -: tag_w];
         end else begin
            saw_stall = saw_stall | stall_of(port);  // busy while the miss runs
            waited++;
         end
      end
      check_true(seen, $sformatf("port %0d access to %h never completed", port, a));
      if (seen && hit_exp) begin
         check_count($sformatf("port %0d hit cycles", port), 0, waited);
      end else if (seen) begin
         check_true(waited > 0, $sformatf("port %0d miss on %h done at once", port, a));
         check_true(saw_stall, $sformatf("port %0d stall never rose for miss on %h",
                                         port, a));
      end
      @(posedge clk);
      #2;
      drive(port, 1'b0, 1'b0, a, d);
   endtask

   task automatic read_check(input int port, input logic [addr_w-1:0] a);
      logic [word_w-1:0] got;
      int waited;
      access(port, 1'b0, a, '0, got, waited);
      check_word($sformatf("port %0d read %h", port, a), model_read(a), got);
   endtask

   task automatic write_op(input int port, input logic [addr_w-1:0] a,
                           input logic [word_w-1:0] d);
      logic [word_w-1:0] got;
      int waited;
      access(port, 1'b1, a, d, got, waited);
   endtask

   task automatic random_op(input int port);
      logic [addr_w-1:0] a;
      a = pick_addr(port);
      if ($urandom_range(1, 0) == 1) begin
         write_op(port, a, word_w'($urandom));
      end else begin
         read_check(port, a);
      end
   endtask

   task automatic client(input int port, input int n);
      repeat (n) random_op(port);
   endtask

   // rd and wr together: err without done, request dropped
   task automatic error_request(input int port);
      bit saw_err;
      bit saw_done;
      int n;
      saw_err  = 1'b0;
      saw_done = 1'b0;
      n = 0;
      @(posedge clk);
      #2;
      drive(port, 1'b1, 1'b1, pick_addr(port), '0);
      while (!saw_err && n < 8) begin
         @(negedge clk);
         saw_err  = err_of(port);
         saw_done = saw_done | done_of(port);
         n++;
      end
      check_true(saw_err, "err never pulsed for rd and wr together");
      check_true(!saw_done, "done pulsed for a dropped request");
      @(posedge clk);
      #2;
      drive(port, 1'b0, 1'b0, '0, '0);
      @(negedge clk);
      check_true(!err_of(port) && !done_of(port), "err or done still high after release");
   endtask

   initial begin
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] b;
      logic [word_w-1:0] d;
      logic [word_w-1:0] got;
      int waited;

      void'($urandom(77));
      n_checks = 0;
      n_errors = 0;
      rst_n = 1'b0;
      drive(0, 1'b0, 1'b0, '0, '0);
      drive(1, 1'b0, 1'b0, '0, '0);
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;

      start_test("cold_reads");
      @(negedge clk);
      check_true(!done_0 && !done_1 && !err_0 && !err_1 && !stall_0 && !stall_1,
                 "outputs not quiet after reset");
      for (int i = 0; i < 4; i++) begin
         read_check(1, pick_addr(1));
      end
      for (int i = 0; i < 6; i++) begin
         a = pick_addr(0);
         read_check(0, a);
      end
      finish_test();

      start_test("hit_timing");  // whole line of the last cold read is resident
      for (int off = 0; off < words_per_line; off++) begin
         b = {a[addr_w-1:offset_w], offset_w'(off)};
         access(0, 1'b0, b, '0, got, waited);
         check_count("done cycle", 0, waited);
         check_word("hit data", model_read(b), got);
      end
      finish_test();

      start_test("read_after_write");
      client(0, n_raw);
      finish_test();

      start_test("dirty_eviction");
      for (int r = 0; r < 3; r++) begin
         a = {tag_w'(1), index_w'(r), offset_w'(r)};
         b = {tag_w'(2), index_w'(r), offset_w'(r)};  // same line slot, other tag
         d = word_w'($urandom);
         write_op(0, a, d);
         read_check(0, b);
         read_check(0, a);  // only right if the writeback landed
      end
      finish_test();

      start_test("contention");
      fork
         client(0, n_contend);
         client(1, n_contend);
      join
      finish_test();

      start_test("error_request");
      error_request(1);
      read_check(1, pick_addr(1));
      finish_test();

      $display("total: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/mem_arbiter.sv
rtl/main_mem.sv
rtl/cache_sys_top.sv
test/cache_sys_chk.sv
test/cache_sys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_sys_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
